// File: build.f
+incdir+source
+incdir+testbench
source/samc_pkg.sv
source/asic_port_regs.sv
source/memory_mapper.sv
source/midi_transmitter.sv
source/voice_mixer.sv
source/sigma_delta_dac.sv
source/samc_asic.sv
testbench/tb_samc_asic.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SAM Coupe ASIC testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_samc_asic -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// File: source/asic_port_regs.sv
//==========================================================
// ASIC port registers
// Paging, border and external bank registers, strobes to
// the MIDI and parallel port blocks, and port readback
//==========================================================
`default_nettype none

`include "samc_settings.svh"

module asic_port_regs (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         ext_ram_off,
	input  wire samc_pkg::cpu_addr_t    cpu_addr,
	input  wire samc_pkg::port_data_t   write_data,
	input  wire                         port_write,
	input  wire                         port_read,
	input  wire                         int_midi,
	output samc_pkg::port_data_t        lmpr,
	output samc_pkg::port_data_t        hmpr,
	output samc_pkg::port_data_t        ext_c,
	output samc_pkg::port_data_t        ext_d,
	output logic                        ext_disabled,
	output logic                        ear,
	output logic                        midi_write_stb,
	output logic                        lpt_data_stb,
	output logic                        lpt_strobe_stb,
	output samc_pkg::port_data_t        read_data
);
	import samc_pkg::*;

	logic       port_write_q;
	logic       write_edge;
	port_data_t port_addr;

	assign port_addr  = cpu_addr[7:0];
	assign write_edge = port_write & ~port_write_q;

	//==========================================================
	// Register writes on the rising edge of port_write
	//==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_write_q <= 1'b0;
			lmpr         <= '0;
			hmpr         <= '0;
			ear          <= 1'b0;
			ext_c        <= '0;
			ext_d        <= '0;
			// Ext RAM config only taken while in reset
			ext_disabled <= ext_ram_off;
		end else begin
			port_write_q <= port_write;
			if (write_edge) begin
				case (port_addr)
					`SAMC_PORT_LMPR:   lmpr  <= write_data;
					`SAMC_PORT_HMPR:   hmpr  <= write_data;
					// Only the ear bit of the border has a user here
					`SAMC_PORT_BORDER: ear   <= write_data[4];
					`SAMC_PORT_EXT_C:  ext_c <= write_data;
					`SAMC_PORT_EXT_D:  ext_d <= write_data;
					default: ;
				endcase
			end
		end
	end

	// One-cycle strobes on the same clock as the register update
	assign midi_write_stb = write_edge & (port_addr == `SAMC_PORT_MIDI);
	assign lpt_data_stb   = write_edge & (port_addr == `SAMC_PORT_LPT_DATA);
	assign lpt_strobe_stb = write_edge & (port_addr == `SAMC_PORT_LPT_STROBE);

	//==========================================================
	// Readback
	//==========================================================
	always_comb begin
		read_data = 8'hFF;
		if (port_read) begin
			case (port_addr)
				`SAMC_PORT_LMPR:   read_data = lmpr;
				`SAMC_PORT_HMPR:   read_data = hmpr;
				// Keyboard, frame and line bits idle high
				`SAMC_PORT_STATUS: read_data = {3'b111, ~int_midi, 4'b1111};
				default:           read_data = 8'hFF;
			endcase
		end
	end

	a_strobe_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		(midi_write_stb | lpt_data_stb | lpt_strobe_stb)
		|=> !(midi_write_stb | lpt_data_stb | lpt_strobe_stb));

endmodule

`default_nettype wire

// File: source/memory_mapper.sv
//==========================================================
// Memory mapper
// CPU address to flat RAM/ROM address, with write gating
//==========================================================
`default_nettype none

`include "samc_settings.svh"

module memory_mapper (
	input  wire samc_pkg::cpu_addr_t    cpu_addr,
	input  wire samc_pkg::port_data_t   lmpr,
	input  wire samc_pkg::port_data_t   hmpr,
	input  wire samc_pkg::port_data_t   ext_c,
	input  wire samc_pkg::port_data_t   ext_d,
	input  wire                         ext_disabled,
	input  wire                         mem_req,
	input  wire                         mem_write,
	output samc_pkg::ram_addr_t         ram_addr,
	output logic                        ram_we
);
	import samc_pkg::*;

	logic [1:0] quarter;
	logic       rom0_sel;
	logic       rom1_sel;
	logic       rom_sel;
	logic       ram_wp;
	logic       ext_win;
	logic [4:0] low_page;
	logic [4:0] high_page;
	page_t      page;

	assign quarter   = cpu_addr[15:14];
	assign rom0_sel  = ~lmpr[5] & (quarter == 2'd0);
	assign rom1_sel  = lmpr[6] & (quarter == 2'd3);
	assign rom_sel   = rom0_sel | rom1_sel;
	assign ram_wp    = lmpr[7] & (quarter == 2'd0);
	assign ext_win   = hmpr[7] & cpu_addr[15];

	// Odd quarter takes the following page and wraps in 5 bits
	assign low_page  = lmpr[4:0] + {4'd0, quarter[0]};
	assign high_page = hmpr[4:0] + {4'd0, quarter[0]};

	always_comb begin
		if (rom_sel)
			page = {3'b000, `SAMC_ROM_BANK, cpu_addr[15]};
		else if (ext_win)
			page = `SAMC_EXT_BASE + page_t'(quarter[0] ? ext_d : ext_c);
		else if (quarter[1])
			page = {4'd0, high_page};
		else
			page = {4'd0, low_page};
	end

	assign ram_addr = {page, cpu_addr[13:0]};
	assign ram_we   = mem_req & mem_write & ~rom_sel & ~ram_wp & ~(ext_win & ext_disabled);

endmodule

`default_nettype wire

// File: source/midi_transmitter.sv
//==========================================================
// MIDI transmit timer
// Byte-time counter on a 1 MHz tick, one pending byte
//==========================================================
`default_nettype none

`include "samc_settings.svh"

module midi_transmitter (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  midi_write_stb,
	output logic midi_busy,
	output logic int_midi
);
	localparam int DIV_W = $clog2(`SAMC_CE_1M_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic             ce_1m;
	logic             pending;
	logic             start;
	logic [8:0]       tx_time;

	assign ce_1m = (div_cnt == DIV_W'(`SAMC_CE_1M_DIV - 1));
	// Next byte only once the previous one is done
	assign start = ce_1m & ~midi_busy & pending;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt   <= '0;
			pending   <= 1'b0;
			tx_time   <= '0;
			midi_busy <= 1'b0;
			int_midi  <= 1'b0;
		end else begin
			div_cnt <= ce_1m ? '0 : div_cnt + 1'b1;

			// Writes during a byte merge into one
			pending <= (pending & ~start) | midi_write_stb;

			if (ce_1m) begin
				if (start) begin
					midi_busy <= 1'b1;
					tx_time   <= `SAMC_MIDI_BIT_TICKS;
				end else if (midi_busy) begin
					if (tx_time == 9'd0) begin
						midi_busy <= 1'b0;
						int_midi  <= 1'b0;
					end else begin
						tx_time <= tx_time - 9'd1;
						// Near the end of the byte
						if (tx_time == `SAMC_MIDI_INT_TICK)
							int_midi <= 1'b1;
					end
				end
			end
		end
	end

	a_int_in_busy: assert property (@(posedge clk_sys) disable iff (reset)
		int_midi |-> midi_busy);

endmodule

`default_nettype wire

// File: source/samc_asic.sv
//==========================================================
// SAM Coupe ASIC top level
// Port registers, memory paging, MIDI timer and audio
//==========================================================
`default_nettype none

`include "samc_settings.svh"

module samc_asic (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         ext_ram_off,
	input  wire samc_pkg::cpu_addr_t    cpu_addr,
	input  wire samc_pkg::port_data_t   write_data,
	input  wire                         port_write,
	input  wire                         port_read,
	input  wire                         mem_req,
	input  wire                         mem_write,
	output samc_pkg::port_data_t        read_data,
	output samc_pkg::ram_addr_t         ram_addr,
	output logic                        ram_we,
	output logic                        midi_busy,
	output logic                        int_midi,
	output logic                        audio_l,
	output logic                        audio_r
);
	import samc_pkg::*;

	port_data_t  lmpr;
	port_data_t  hmpr;
	port_data_t  ext_c;
	port_data_t  ext_d;
	logic        ext_disabled;
	logic        ear;
	logic        midi_write_stb;
	logic        lpt_data_stb;
	logic        lpt_strobe_stb;
	dac_sample_t sample_l;
	dac_sample_t sample_r;

	asic_port_regs u_port_regs (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ext_ram_off    (ext_ram_off),
		.cpu_addr       (cpu_addr),
		.write_data     (write_data),
		.port_write     (port_write),
		.port_read      (port_read),
		.int_midi       (int_midi),
		.lmpr           (lmpr),
		.hmpr           (hmpr),
		.ext_c          (ext_c),
		.ext_d          (ext_d),
		.ext_disabled   (ext_disabled),
		.ear            (ear),
		.midi_write_stb (midi_write_stb),
		.lpt_data_stb   (lpt_data_stb),
		.lpt_strobe_stb (lpt_strobe_stb),
		.read_data      (read_data)
	);

	memory_mapper u_mapper (
		.cpu_addr     (cpu_addr),
		.lmpr         (lmpr),
		.hmpr         (hmpr),
		.ext_c        (ext_c),
		.ext_d        (ext_d),
		.ext_disabled (ext_disabled),
		.mem_req      (mem_req),
		.mem_write    (mem_write),
		.ram_addr     (ram_addr),
		.ram_we       (ram_we)
	);

	midi_transmitter u_midi (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.midi_write_stb (midi_write_stb),
		.midi_busy      (midi_busy),
		.int_midi       (int_midi)
	);

	//==========================================================
	// Audio
	//==========================================================
	voice_mixer u_voice (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.write_data     (write_data),
		.lpt_data_stb   (lpt_data_stb),
		.lpt_strobe_stb (lpt_strobe_stb),
		.ear            (ear),
		.sample_l       (sample_l),
		.sample_r       (sample_r)
	);

	sigma_delta_dac #(.WIDTH(`SAMC_DAC_WIDTH)) u_dac_l (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sample  (sample_l),
		.bit_out (audio_l)
	);

	sigma_delta_dac #(.WIDTH(`SAMC_DAC_WIDTH)) u_dac_r (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sample  (sample_r),
		.bit_out (audio_r)
	);

endmodule

`default_nettype wire

// File: source/samc_pkg.sv
//==========================================================
// SAM Coupe ASIC shared types
// Bus, page, flat address and audio sample types
//==========================================================
`default_nettype none

`include "samc_settings.svh"

package samc_pkg;

	// CPU side of the bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  port_data_t;

	// 16 KB page number in the flat RAM/ROM space
	typedef logic [8:0]  page_t;

	// Page number on top, 14-bit offset below
	typedef logic [22:0] ram_addr_t;

	// Mixed sample fed to the sigma-delta DACs
	typedef logic [`SAMC_DAC_WIDTH-1:0] dac_sample_t;

endpackage

`default_nettype wire

// File: source/samc_settings.svh
//==========================================================
// SAM Coupe ASIC constants
// Port numbers, memory map bases, MIDI timing, DAC width
//==========================================================
`ifndef SAMC_SETTINGS_SVH
`define SAMC_SETTINGS_SVH

// I/O ports, matched against the low address byte
`define SAMC_PORT_LMPR        8'hFA
`define SAMC_PORT_HMPR        8'hFB
`define SAMC_PORT_BORDER      8'hFE
`define SAMC_PORT_STATUS      8'hF9
`define SAMC_PORT_MIDI        8'hFD
`define SAMC_PORT_LPT_DATA    8'hE8
`define SAMC_PORT_LPT_STROBE  8'hE9
`define SAMC_PORT_EXT_C       8'h80
`define SAMC_PORT_EXT_D       8'h81

// Memory map
`define SAMC_ROM_BANK         5'h10
`define SAMC_EXT_BASE         9'h040

// System clocks per 1 MHz tick
`define SAMC_CE_1M_DIV        48

// MIDI byte time, in 1 MHz ticks
`define SAMC_MIDI_BIT_TICKS   9'd319
`define SAMC_MIDI_INT_TICK    9'd15

// Mixed audio sample width
`define SAMC_DAC_WIDTH        10

`endif

// File: source/sigma_delta_dac.sv
//==========================================================
// First-order sigma-delta DAC
// Accumulator carry as a 1-bit density stream
//==========================================================
`default_nettype none

`include "samc_settings.svh"

module sigma_delta_dac #(
	parameter int WIDTH = `SAMC_DAC_WIDTH
) (
	input  wire              clk_sys,
	input  wire              reset,
	input  wire [WIDTH-1:0]  sample,
	output logic             bit_out
);
	logic [WIDTH-1:0] acc;

	// Ones per 2^WIDTH cycles equal the sample value
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc     <= '0;
			bit_out <= 1'b0;
		end else begin
			{bit_out, acc} <= {1'b0, acc} + {1'b0, sample};
		end
	end

endmodule

`default_nettype wire

// File: source/voice_mixer.sv
//==========================================================
// Parallel port voice DAC and mixer
// Stereo voice latch plus border ear bit into samples
//==========================================================
`default_nettype none

`include "samc_settings.svh"

module voice_mixer (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire samc_pkg::port_data_t   write_data,
	input  wire                         lpt_data_stb,
	input  wire                         lpt_strobe_stb,
	input  wire                         ear,
	output samc_pkg::dac_sample_t       sample_l,
	output samc_pkg::dac_sample_t       sample_r
);
	import samc_pkg::*;

	port_data_t  lpt_data;
	port_data_t  vox_l;
	port_data_t  vox_r;
	logic        strobe_q;
	dac_sample_t ear_level;

	// Data port byte, waiting for a strobe edge
	always_ff @(posedge clk_sys) begin
		if (reset)
			lpt_data <= '0;
		else if (lpt_data_stb)
			lpt_data <= write_data;
	end

	assign ear_level = ear ? dac_sample_t'(256) : '0;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vox_l    <= '0;
			vox_r    <= '0;
			strobe_q <= 1'b0;
			sample_l <= '0;
			sample_r <= '0;
		end else begin
			if (lpt_strobe_stb) begin
				// Rising strobe bit feeds left, falling feeds right
				if (~strobe_q & write_data[0])
					vox_l <= lpt_data;
				if (strobe_q & ~write_data[0])
					vox_r <= lpt_data;
				strobe_q <= write_data[0];
			end
			sample_l <= dac_sample_t'({vox_l, 1'b0}) + ear_level;
			sample_r <= dac_sample_t'({vox_r, 1'b0}) + ear_level;
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_samc_tests.svh
//==========================================================
// SAM Coupe ASIC directed tests
// Reset state, paging, external RAM, MIDI timer, audio
//==========================================================
`ifndef TB_SAMC_TESTS_SVH
`define TB_SAMC_TESTS_SVH

// Page number on top of a 14-bit offset
function automatic ram_addr_t flat_addr(input logic [8:0] page, input logic [13:0] offset);
	flat_addr = {page, offset};
endfunction

task automatic test_reset_state();
	port_data_t rd;
	ram_addr_t  addr;
	logic       we;

	port_rd(`SAMC_PORT_LMPR, rd);
	check_value("LMPR after reset", rd, 8'h00);
	port_rd(`SAMC_PORT_HMPR, rd);
	check_value("HMPR after reset", rd, 8'h00);
	port_rd(`SAMC_PORT_STATUS, rd);
	check_value("status after reset", rd, 8'hFF);
	// ROM0 fills quarter 0 out of reset
	mem_access(16'h2345, 1'b1, addr, we);
	check_value("ROM0 address", addr, flat_addr({3'b000, `SAMC_ROM_BANK, 1'b0}, 14'h2345));
	check_value("ram_we on ROM0", we, 1'b0);
	@(negedge clk_sys);
	check_value("midi_busy after reset", midi_busy, 1'b0);
	check_value("int_midi after reset", int_midi, 1'b0);
endtask

task automatic test_paging();
	logic [31:0] rnd;
	logic [4:0]  lp;
	logic [4:0]  hp;
	logic [13:0] offset;
	logic [4:0]  exp_page [4];
	port_data_t  rd;
	ram_addr_t   addr;
	logic        we;

	for (int round = 0; round < 4; round++) begin
		random_bits(5, rnd);
		lp = rnd[4:0];
		random_bits(5, rnd);
		hp = rnd[4:0];
		random_bits(14, rnd);
		offset = rnd[13:0];
		// Bit 5 set pages RAM into quarter 0
		port_wr(`SAMC_PORT_LMPR, {3'b001, lp});
		port_wr(`SAMC_PORT_HMPR, {3'b000, hp});
		port_rd(`SAMC_PORT_LMPR, rd);
		check_value("LMPR readback", rd, {3'b001, lp});
		port_rd(`SAMC_PORT_HMPR, rd);
		check_value("HMPR readback", rd, {3'b000, hp});
		exp_page[0] = lp;
		exp_page[1] = lp + 5'd1;
		exp_page[2] = hp;
		exp_page[3] = hp + 5'd1;
		for (int q = 0; q < 4; q++) begin
			mem_access({2'(q), offset}, 1'b1, addr, we);
			check_value("paged address", addr, flat_addr({4'h0, exp_page[q]}, offset));
			check_value("paged ram_we", we, 1'b1);
		end
	end

	// ROM1 takes over quarter 3
	port_wr(`SAMC_PORT_LMPR, {3'b011, lp});
	mem_access({2'd3, offset}, 1'b1, addr, we);
	check_value("ROM1 address", addr, flat_addr({3'b000, `SAMC_ROM_BANK, 1'b1}, offset));
	check_value("ram_we on ROM1", we, 1'b0);
	mem_access({2'd2, offset}, 1'b1, addr, we);
	check_value("quarter 2 beside ROM1", addr, flat_addr({4'h0, hp}, offset));

	// Write protect on quarter 0 alone
	port_wr(`SAMC_PORT_LMPR, {3'b101, lp});
	mem_access({2'd0, offset}, 1'b1, addr, we);
	check_value("protected address", addr, flat_addr({4'h0, lp}, offset));
	check_value("ram_we when protected", we, 1'b0);
	mem_access({2'd1, offset}, 1'b1, addr, we);
	check_value("ram_we in quarter 1", we, 1'b1);
	mem_access({2'd1, offset}, 1'b0, addr, we);
	check_value("ram_we on a read", we, 1'b0);
	port_rd(`SAMC_PORT_LMPR, rd);
	check_value("LMPR readback with protect", rd, {3'b101, lp});
endtask

task automatic test_ext_ram();
	logic [31:0] rnd;
	port_data_t  ec;
	port_data_t  ed;
	logic [13:0] offset;
	ram_addr_t   addr;
	logic        we;

	random_bits(8, rnd);
	ec = rnd[7:0];
	random_bits(8, rnd);
	ed = rnd[7:0];
	random_bits(14, rnd);
	offset = rnd[13:0];
	// Second round has the window switched off at reset
	for (int cfg = 0; cfg < 2; cfg++) begin
		apply_reset(cfg == 1);
		port_wr(`SAMC_PORT_LMPR, 8'h20);
		port_wr(`SAMC_PORT_EXT_C, ec);
		port_wr(`SAMC_PORT_EXT_D, ed);
		port_wr(`SAMC_PORT_HMPR, 8'h80);
		mem_access({2'd2, offset}, 1'b1, addr, we);
		check_value("ext C address", addr, flat_addr(`SAMC_EXT_BASE + {1'b0, ec}, offset));
		check_value("ext C ram_we", we, cfg == 0);
		mem_access({2'd3, offset}, 1'b1, addr, we);
		check_value("ext D address", addr, flat_addr(`SAMC_EXT_BASE + {1'b0, ed}, offset));
		check_value("ext D ram_we", we, cfg == 0);
	end
	apply_reset(1'b0);
endtask

task automatic test_midi();
	int   cycles;
	int   busy_cycles;
	logic saw_int;

	port_wr(`SAMC_PORT_MIDI, 8'h90);
	wait_busy(1'b1, 60, cycles);
	// Status port stays on the bus for the whole byte
	@(posedge clk_sys);
	cpu_addr  <= {8'h00, `SAMC_PORT_STATUS};
	port_read <= 1'b1;
	busy_cycles = 1;
	saw_int     = 1'b0;
	@(negedge clk_sys);
	while (midi_busy === 1'b1) begin
		check_value("status bit 4", read_data[4], !int_midi);
		if (int_midi === 1'b1)
			saw_int = 1'b1;
		if (busy_cycles > 15360 + 60)
			abort_run("timeout: midi_busy stayed high past the byte time");
		else begin
			@(negedge clk_sys);
			busy_cycles++;
		end
	end
	check_value("int_midi after busy", int_midi, 1'b0);
	check_value("int_midi seen", saw_int, 1'b1);
	check_value("busy length in range", busy_cycles >= 15300 && busy_cycles <= 15420, 1'b1);
	@(posedge clk_sys);
	port_read <= 1'b0;

	// Later writes merge into one pending byte
	port_wr(`SAMC_PORT_MIDI, 8'h3C);
	wait_busy(1'b1, 60, cycles);
	port_wr(`SAMC_PORT_MIDI, 8'h40);
	port_wr(`SAMC_PORT_MIDI, 8'h7F);
	@(negedge clk_sys);
	check_value("busy during merged writes", midi_busy, 1'b1);
	wait_busy(1'b0, 15360 + 60, cycles);
	wait_busy(1'b1, 60, cycles);
	wait_busy(1'b0, 15360 + 60, cycles);
	check_value("merged byte length in range", cycles >= 15300 && cycles <= 15420, 1'b1);
	repeat (200) begin
		@(negedge clk_sys);
		check_value("no third byte", midi_busy, 1'b0);
	end
endtask

task automatic test_voice_audio();
	logic [31:0] rnd;
	port_data_t  vl;
	port_data_t  vr;
	int          ones_l;
	int          ones_r;

	for (int ear_bit = 1; ear_bit >= 0; ear_bit--) begin
		random_bits(8, rnd);
		vl = rnd[7:0];
		random_bits(8, rnd);
		vr = rnd[7:0];
		// Rising strobe bit selects left, falling selects right
		port_wr(`SAMC_PORT_LPT_DATA, vl);
		port_wr(`SAMC_PORT_LPT_STROBE, 8'h01);
		port_wr(`SAMC_PORT_LPT_DATA, vr);
		port_wr(`SAMC_PORT_LPT_STROBE, 8'h00);
		port_wr(`SAMC_PORT_BORDER, (ear_bit == 1) ? 8'h10 : 8'h00);
		// Sample register, then DAC accumulator
		repeat (2) @(posedge clk_sys);
		ones_l = 0;
		ones_r = 0;
		repeat (1024) begin
			@(negedge clk_sys);
			ones_l += int'(audio_l);
			ones_r += int'(audio_r);
		end
		check_value("left ones count", ones_l, 2 * vl + 256 * ear_bit);
		check_value("right ones count", ones_r, 2 * vr + 256 * ear_bit);
	end
endtask

`endif

// File: testbench/tb_samc_asic.sv
//==========================================================
// SAM Coupe ASIC testbench
// Bus driver tasks, checks, wait loops and test sequence
//==========================================================
`default_nettype none

`include "samc_settings.svh"

module tb_samc_asic;
	timeunit 1ns;
	timeprecision 1ns;

	import samc_pkg::*;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        ext_ram_off;
	cpu_addr_t   cpu_addr;
	port_data_t  write_data;
	logic        port_write;
	logic        port_read;
	logic        mem_req;
	logic        mem_write;
	port_data_t  read_data;
	ram_addr_t   ram_addr;
	logic        ram_we;
	logic        midi_busy;
	logic        int_midi;
	logic        audio_l;
	logic        audio_r;
	logic [31:0] lfsr_state;

	always #20 clk_sys = ~clk_sys;

	samc_asic u_samc_asic (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ext_ram_off (ext_ram_off),
		.cpu_addr    (cpu_addr),
		.write_data  (write_data),
		.port_write  (port_write),
		.port_read   (port_read),
		.mem_req     (mem_req),
		.mem_write   (mem_write),
		.read_data   (read_data),
		.ram_addr    (ram_addr),
		.ram_we      (ram_we),
		.midi_busy   (midi_busy),
		.int_midi    (int_midi),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	//==========================================================
	// Failure handling and checks
	//==========================================================
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			abort_run($sformatf("error at %0t ns: %s is %0h, expected %0h",
				$time, what, actual, expected));
	endtask

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		lfsr_step = {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic random_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value      = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	//==========================================================
	// Bus tasks
	//==========================================================
	task automatic apply_reset(input logic ext_off);
		@(posedge clk_sys);
		reset       <= 1'b1;
		ext_ram_off <= ext_off;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	// Strobe held for two clocks, edge seen on the first
	task automatic port_wr(input port_data_t port, input port_data_t data);
		@(posedge clk_sys);
		cpu_addr   <= {8'h00, port};
		write_data <= data;
		port_write <= 1'b1;
		repeat (2) @(posedge clk_sys);
		port_write <= 1'b0;
	endtask

	task automatic port_rd(input port_data_t port, output port_data_t data);
		@(posedge clk_sys);
		cpu_addr  <= {8'h00, port};
		port_read <= 1'b1;
		@(negedge clk_sys);
		data = read_data;
		@(posedge clk_sys);
		port_read <= 1'b0;
	endtask

	task automatic mem_access(input cpu_addr_t addr, input logic write,
		output ram_addr_t addr_out, output logic we_out);
		@(posedge clk_sys);
		cpu_addr  <= addr;
		mem_req   <= 1'b1;
		mem_write <= write;
		@(negedge clk_sys);
		addr_out = ram_addr;
		we_out   = ram_we;
		@(posedge clk_sys);
		mem_req   <= 1'b0;
		mem_write <= 1'b0;
	endtask

	task automatic wait_busy(input logic level, input int limit, output int cycles);
		cycles = 0;
		@(negedge clk_sys);
		while (midi_busy !== level) begin
			if (cycles >= limit)
				abort_run($sformatf("timeout: midi_busy did not go to %0b within %0d cycles",
					level, limit));
			else begin
				@(negedge clk_sys);
				cycles++;
			end
		end
	endtask

	`include "tb_samc_tests.svh"

	initial begin
		lfsr_state  = 32'h114d_50c7;
		reset       = 1'b1;
		ext_ram_off = 1'b0;
		cpu_addr    = '0;
		write_data  = '0;
		port_write  = 1'b0;
		port_read   = 1'b0;
		mem_req     = 1'b0;
		mem_write   = 1'b0;
		apply_reset(1'b0);
		test_reset_state();
		test_paging();
		test_ext_ram();
		test_midi();
		test_voice_audio();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
